// ==== verilog/lsu_pipe_pkg.sv ====
`default_nettype none

package lsu_pipe_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  rd_t;
    typedef logic [2:0]  func3_t;
    typedef logic [3:0]  ctrl_t;

    // control field bit positions, EX to MEM
    localparam int CTRL_RD      = 3;
    localparam int CTRL_WR      = 2;
    localparam int CTRL_SEL_MEM = 1;
    localparam int CTRL_WE      = 0;

    // access size, RV32 load/store coding
    localparam func3_t F3_B  = 3'd0;
    localparam func3_t F3_H  = 3'd1;
    localparam func3_t F3_W  = 3'd2;
    localparam func3_t F3_BU = 3'd4;
    localparam func3_t F3_HU = 3'd5;

    typedef enum logic [1:0] {
        INST_ALU,
        INST_LOAD,
        INST_STORE
    } inst_kind_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

endpackage

`default_nettype wire

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     in_valid_i,
    input  lsu_pipe_pkg::inst_kind_t in_kind_i,
    input  lsu_pipe_pkg::alu_op_t   in_alu_op_i,
    input  lsu_pipe_pkg::func3_t    in_func3_i,
    input  lsu_pipe_pkg::rd_t       in_rd_i,
    input  lsu_pipe_pkg::data_t     in_src1_i,
    input  lsu_pipe_pkg::data_t     in_src2_i,
    input  lsu_pipe_pkg::data_t     in_imm_i,
    input  wire                     allow_in_mem_i,
    output logic                    in_allow_o,
    output logic                    valid_ex_o,
    output lsu_pipe_pkg::data_t     result_o,
    output lsu_pipe_pkg::data_t     store_data_o,
    output lsu_pipe_pkg::ctrl_t     ctrl_o,
    output lsu_pipe_pkg::func3_t    func3_o,
    output lsu_pipe_pkg::rd_t       rd_o
);
    import lsu_pipe_pkg::*;

    logic       valid_q;
    inst_kind_t kind_q;
    alu_op_t    alu_op_q;
    func3_t     func3_q;
    rd_t        rd_q;
    data_t      src1_q;
    data_t      src2_q;
    data_t      imm_q;
    data_t      alu_res;

    // execute never stalls, so it only waits on the memory stage
    assign in_allow_o = !valid_q || allow_in_mem_i;
    assign valid_ex_o = valid_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (in_allow_o)
        begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid_i && in_allow_o)
        begin
            kind_q   <= in_kind_i;
            alu_op_q <= in_alu_op_i;
            func3_q  <= in_func3_i;
            rd_q     <= in_rd_i;
            src1_q   <= in_src1_i;
            src2_q   <= in_src2_i;
            imm_q    <= in_imm_i;
        end
    end

    always_comb
    begin
        case (alu_op_q)
            ALU_ADD: alu_res = src1_q + src2_q;
            ALU_SUB: alu_res = src1_q - src2_q;
            ALU_AND: alu_res = src1_q & src2_q;
            ALU_OR:  alu_res = src1_q | src2_q;
            ALU_XOR: alu_res = src1_q ^ src2_q;
            ALU_SLL: alu_res = src1_q << src2_q[4:0];
            ALU_SRL: alu_res = src1_q >> src2_q[4:0];
            ALU_SLT: alu_res = {31'd0, $signed(src1_q) < $signed(src2_q)};
            default: alu_res = '0;
        endcase
    end

    // loads and stores carry their address in the result field
    always_comb
    begin
        ctrl_o = '0;
        case (kind_q)
            INST_LOAD:
            begin
                result_o              = src1_q + imm_q;
                ctrl_o[CTRL_RD]       = 1'b1;
                ctrl_o[CTRL_SEL_MEM]  = 1'b1;
                ctrl_o[CTRL_WE]       = 1'b1;
            end
            INST_STORE:
            begin
                result_o        = src1_q + imm_q;
                ctrl_o[CTRL_WR] = 1'b1;
            end
            default:
            begin
                result_o        = alu_res;
                ctrl_o[CTRL_WE] = 1'b1;
            end
        endcase
    end

    assign store_data_o = src2_q;
    assign func3_o      = func3_q;
    assign rd_o         = rd_q;

endmodule

`default_nettype wire

// ==== verilog/ex_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush_i,
    input  wire                        hold_i,
    input  wire                        mem_addr_ok_i,
    input  lsu_pipe_pkg::data_t        mem_address_i,
    input  lsu_pipe_pkg::data_t        mem_write_data_i,
    input  lsu_pipe_pkg::ctrl_t        control_flow_i,
    input  lsu_pipe_pkg::rd_t          rd_ex_i,
    input  lsu_pipe_pkg::func3_t       func3_i,
    input  wire                        allow_in_wb_i,
    input  wire                        valid_ex_i,
    output logic                       ram_req_o,
    output logic [ADDR_WIDTH-1:0]      mem_address_o,
    output lsu_pipe_pkg::data_t        mem_write_data_o,
    output logic [1:0]                 control_flow_o,
    output logic                       mem_write_o,
    output logic                       mem_read_o,
    output lsu_pipe_pkg::rd_t          rd_mem_o,
    output lsu_pipe_pkg::func3_t       func3_o,
    output lsu_pipe_pkg::data_t        result_o,
    output logic                       valid_mem_o,
    output logic                       ready_go_mem_o,
    output logic                       allow_in_mem_o
);
    import lsu_pipe_pkg::*;

    logic   valid_q;
    ctrl_t  ctrl_q;
    data_t  result_q;
    data_t  wdata_q;
    rd_t    rd_q;
    func3_t func3_q;
    logic   pipe_valid;
    logic   mem_type;

    // flush drops whatever execute hands over this cycle
    assign pipe_valid = valid_ex_i && !flush_i;

    assign mem_read_o  = ctrl_q[CTRL_RD] && valid_q;
    assign mem_write_o = ctrl_q[CTRL_WR] && valid_q;
    assign mem_type    = mem_read_o || mem_write_o;

    assign ram_req_o = valid_q && mem_type && !hold_i && allow_in_wb_i;

    // non-memory ops are done here unless the stage is held
    always_comb
    begin
        if (mem_type)
        begin
            ready_go_mem_o = ram_req_o && mem_addr_ok_i;
        end
        else
        begin
            ready_go_mem_o = !hold_i;
        end
    end

    assign allow_in_mem_o = !valid_q || (ready_go_mem_o && allow_in_wb_i);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (allow_in_mem_o)
        begin
            valid_q <= pipe_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_valid && allow_in_mem_o)
        begin
            ctrl_q   <= control_flow_i;
            result_q <= mem_address_i;
            wdata_q  <= mem_write_data_i;
            rd_q     <= rd_ex_i;
            func3_q  <= func3_i;
        end
    end

    assign valid_mem_o      = valid_q;
    assign result_o         = result_q;
    assign mem_address_o    = result_q[ADDR_WIDTH-1:0];
    assign mem_write_data_o = wdata_q;
    assign control_flow_o   = ctrl_q[1:0] & {2{valid_q}};
    assign rd_mem_o         = rd_q;
    assign func3_o          = func3_q;

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   ram_req_i,
    input  wire                   mem_read_i,
    input  wire                   mem_write_i,
    input  wire [ADDR_WIDTH-1:0]  addr_i,
    input  lsu_pipe_pkg::data_t   wdata_i,
    input  lsu_pipe_pkg::func3_t  func3_i,
    output logic                  addr_ok_o,
    output lsu_pipe_pkg::data_t   rdata_o
);
    import lsu_pipe_pkg::*;

    localparam int WORDS = 1 << (ADDR_WIDTH - 2);

    typedef enum logic {
        ST_IDLE,
        ST_MERGE
    } ram_state_t;

    ram_state_t            state_q;
    data_t                 mem [WORDS];
    logic [ADDR_WIDTH-3:0] word_addr;
    logic [ADDR_WIDTH-3:0] merge_addr_q;
    data_t                 old_word_q;
    data_t                 lane_mask_q;
    data_t                 lane_data_q;
    data_t                 lane_mask;
    data_t                 lane_data;
    logic                  accept;
    logic                  sub_word;

    initial
    begin
        for (int i = 0; i < WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    assign word_addr = addr_i[ADDR_WIDTH-1:2];
    assign addr_ok_o = (state_q == ST_IDLE);
    assign accept    = ram_req_i && addr_ok_o;
    assign sub_word  = (func3_i[1:0] != F3_W[1:0]);

    // byte lanes touched by a store, address truncated to the access size
    always_comb
    begin
        if (func3_i[1:0] == F3_B[1:0])
        begin
            lane_mask = 32'h0000_00ff << {addr_i[1:0], 3'b000};
            lane_data = {4{wdata_i[7:0]}};
        end
        else
        begin
            lane_mask = 32'h0000_ffff << {addr_i[1], 4'b0000};
            lane_data = {2{wdata_i[15:0]}};
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ST_IDLE;
        end
        else if (state_q == ST_MERGE)
        begin
            state_q <= ST_IDLE;
        end
        else if (accept && mem_write_i && sub_word)
        begin
            state_q <= ST_MERGE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == ST_MERGE)
        begin
            mem[merge_addr_q] <= (old_word_q & ~lane_mask_q) | (lane_data_q & lane_mask_q);
        end
        else if (accept && mem_read_i)
        begin
            rdata_o <= mem[word_addr];
        end
        else if (accept && mem_write_i && !sub_word)
        begin
            mem[word_addr] <= wdata_i;
        end
        else if (accept && mem_write_i)
        begin
            // read half of the read-modify-write
            old_word_q   <= mem[word_addr];
            merge_addr_q <= word_addr;
            lane_mask_q  <= lane_mask;
            lane_data_q  <= lane_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   valid_mem_i,
    input  wire                   ready_go_mem_i,
    input  wire [1:0]             control_flow_i,
    input  lsu_pipe_pkg::data_t   result_i,
    input  lsu_pipe_pkg::data_t   rdata_i,
    input  wire [1:0]             addr_low_i,
    input  lsu_pipe_pkg::func3_t  func3_i,
    input  lsu_pipe_pkg::rd_t     rd_i,
    input  wire                   wb_ready_i,
    output logic                  allow_in_wb_o,
    output logic                  wb_valid_o,
    output lsu_pipe_pkg::rd_t     wb_rd_o,
    output lsu_pipe_pkg::data_t   wb_data_o
);
    import lsu_pipe_pkg::*;

    logic                  valid_q;
    logic [1:0]            ctrl_q;
    data_t                 result_q;
    logic [1:0]            addr_low_q;
    func3_t                func3_q;
    rd_t                   rd_q;
    logic                  pipe_valid;
    data_t                 shifted;
    data_t                 load_data;

    assign pipe_valid    = valid_mem_i && ready_go_mem_i;
    assign allow_in_wb_o = !valid_q || wb_ready_i;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (allow_in_wb_o)
        begin
            valid_q <= pipe_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_valid && allow_in_wb_o)
        begin
            ctrl_q      <= control_flow_i;
            result_q    <= result_i;
            addr_low_q  <= addr_low_i;
            func3_q     <= func3_i;
            rd_q        <= rd_i;
        end
    end

    // ram word arrives on the edge this stage is loaded and stays put
    // until the next load is accepted, which needs this stage to drain
    always_comb
    begin
        case (func3_q)
            F3_B, F3_BU: shifted = rdata_i >> {addr_low_q, 3'b000};
            F3_H, F3_HU: shifted = rdata_i >> {addr_low_q[1], 4'b0000};
            default:     shifted = rdata_i;
        endcase
    end

    always_comb
    begin
        case (func3_q)
            F3_B:    load_data = {{24{shifted[7]}}, shifted[7:0]};
            F3_BU:   load_data = {24'd0, shifted[7:0]};
            F3_H:    load_data = {{16{shifted[15]}}, shifted[15:0]};
            F3_HU:   load_data = {16'd0, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    // stores have no register write and retire without a strobe
    assign wb_valid_o = valid_q && ctrl_q[CTRL_WE];
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = ctrl_q[CTRL_SEL_MEM] ? load_data : result_q;

endmodule

`default_nettype wire

// ==== verilog/lsu_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_top #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      flush_i,
    input  wire                      hold_i,
    input  wire                      wb_ready_i,
    input  wire                      in_valid_i,
    input  lsu_pipe_pkg::inst_kind_t in_kind_i,
    input  lsu_pipe_pkg::alu_op_t    in_alu_op_i,
    input  lsu_pipe_pkg::func3_t     in_func3_i,
    input  lsu_pipe_pkg::rd_t        in_rd_i,
    input  lsu_pipe_pkg::data_t      in_src1_i,
    input  lsu_pipe_pkg::data_t      in_src2_i,
    input  lsu_pipe_pkg::data_t      in_imm_i,
    output logic                     in_allow_o,
    output logic                     wb_valid_o,
    output lsu_pipe_pkg::rd_t        wb_rd_o,
    output lsu_pipe_pkg::data_t      wb_data_o
);
    import lsu_pipe_pkg::*;

    // execute to memory
    logic   valid_ex;
    logic   allow_in_mem;
    data_t  ex_result;
    data_t  ex_store_data;
    ctrl_t  ex_ctrl;
    func3_t ex_func3;
    rd_t    ex_rd;

    // memory stage and ram
    logic                  ram_req;
    logic                  addr_ok;
    logic [ADDR_WIDTH-1:0] mem_address;
    data_t                 mem_wdata;
    data_t                 ram_rdata;
    logic                  mem_write;
    logic                  mem_read;
    logic [1:0]            mem_ctrl;
    rd_t                   mem_rd;
    func3_t                mem_func3;
    data_t                 mem_result;
    logic                  valid_mem;
    logic                  ready_go_mem;
    logic                  allow_in_wb;

    ex_stage i_ex_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid_i),
        .in_kind_i      (in_kind_i),
        .in_alu_op_i    (in_alu_op_i),
        .in_func3_i     (in_func3_i),
        .in_rd_i        (in_rd_i),
        .in_src1_i      (in_src1_i),
        .in_src2_i      (in_src2_i),
        .in_imm_i       (in_imm_i),
        .allow_in_mem_i (allow_in_mem),
        .in_allow_o     (in_allow_o),
        .valid_ex_o     (valid_ex),
        .result_o       (ex_result),
        .store_data_o   (ex_store_data),
        .ctrl_o         (ex_ctrl),
        .func3_o        (ex_func3),
        .rd_o           (ex_rd)
    );

    ex_mem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_ex_mem (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .hold_i           (hold_i),
        .mem_addr_ok_i    (addr_ok),
        .mem_address_i    (ex_result),
        .mem_write_data_i (ex_store_data),
        .control_flow_i   (ex_ctrl),
        .rd_ex_i          (ex_rd),
        .func3_i          (ex_func3),
        .allow_in_wb_i    (allow_in_wb),
        .valid_ex_i       (valid_ex),
        .ram_req_o        (ram_req),
        .mem_address_o    (mem_address),
        .mem_write_data_o (mem_wdata),
        .control_flow_o   (mem_ctrl),
        .mem_write_o      (mem_write),
        .mem_read_o       (mem_read),
        .rd_mem_o         (mem_rd),
        .func3_o          (mem_func3),
        .result_o         (mem_result),
        .valid_mem_o      (valid_mem),
        .ready_go_mem_o   (ready_go_mem),
        .allow_in_mem_o   (allow_in_mem)
    );

    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_data_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .ram_req_i   (ram_req),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .addr_i      (mem_address),
        .wdata_i     (mem_wdata),
        .func3_i     (mem_func3),
        .addr_ok_o   (addr_ok),
        .rdata_o     (ram_rdata)
    );

    mem_wb #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_mem_i    (valid_mem),
        .ready_go_mem_i (ready_go_mem),
        .control_flow_i (mem_ctrl),
        .result_i       (mem_result),
        .rdata_i        (ram_rdata),
        .addr_low_i     (mem_address[1:0]),
        .func3_i        (mem_func3),
        .rd_i           (mem_rd),
        .wb_ready_i     (wb_ready_i),
        .allow_in_wb_o  (allow_in_wb),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_lsu_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_pipe;
    import lsu_pipe_pkg::*;

    localparam int          ADDR_WIDTH   = 12;
    localparam int          RAM_BYTES    = 1 << ADDR_WIDTH;
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'h0a99_4d8e;
    localparam int          N_ALU        = 40;
    localparam int          N_WSTORE     = 12;
    localparam int          N_WLOAD      = 20;
    localparam int          N_SUB        = 60;
    localparam int          N_MIX        = 150;
    localparam int          N_FLUSH      = 9;
    localparam int          TOTAL_INSTS  = N_ALU + N_WSTORE + N_WLOAD + N_SUB + N_MIX + 2 * N_FLUSH;

    logic       clk;
    logic       rst_n;
    logic       flush_i;
    logic       hold_i;
    logic       wb_ready_i;
    logic       in_valid_i;
    inst_kind_t in_kind_i;
    alu_op_t    in_alu_op_i;
    func3_t     in_func3_i;
    rd_t        in_rd_i;
    data_t      in_src1_i;
    data_t      in_src2_i;
    data_t      in_imm_i;
    logic       in_allow_o;
    logic       wb_valid_o;
    rd_t        wb_rd_o;
    data_t      wb_data_o;

    // reference state
    logic [7:0]  mem_model [RAM_BYTES];
    rd_t         exp_rd_q [$];
    data_t       exp_data_q [$];
    int          exp_cyc_q [$];
    logic [31:0] stim_state;
    logic [31:0] stall_state;
    logic        stall_en;
    int          cycle_cnt = 0;
    int          wb_cyc;

    lsu_pipe_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_lsu_pipe_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .hold_i      (hold_i),
        .wb_ready_i  (wb_ready_i),
        .in_valid_i  (in_valid_i),
        .in_kind_i   (in_kind_i),
        .in_alu_op_i (in_alu_op_i),
        .in_func3_i  (in_func3_i),
        .in_rd_i     (in_rd_i),
        .in_src1_i   (in_src1_i),
        .in_src2_i   (in_src2_i),
        .in_imm_i    (in_imm_i),
        .in_allow_o  (in_allow_o),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper half only, the low LCG bits repeat quickly
    function automatic int rand_below(input int n);
        stim_state = lcg_next(stim_state);
        return int'(stim_state[31:16]) % n;
    endfunction

    function automatic data_t rand_word();
        logic [15:0] hi;
        stim_state = lcg_next(stim_state);
        hi = stim_state[31:16];
        stim_state = lcg_next(stim_state);
        return {hi, stim_state[31:16]};
    endfunction

    function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 32'd1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default:
            begin
                // differing signs decide on their own
                if (a[31] != b[31])
                begin
                    return {31'd0, a[31]};
                end
                return {31'd0, a < b};
            end
        endcase
    endfunction

    function automatic data_t load_model(input logic [ADDR_WIDTH-1:0] addr, input func3_t f3);
        logic [ADDR_WIDTH-1:0] hb;
        logic [ADDR_WIDTH-1:0] wa;
        logic [7:0]            b;
        logic [15:0]           h;
        data_t                 w;
        hb = {addr[ADDR_WIDTH-1:1], 1'b0};
        wa = {addr[ADDR_WIDTH-1:2], 2'b00};
        b  = mem_model[addr];
        h  = {mem_model[hb + 1], mem_model[hb]};
        w  = {mem_model[wa + 3], mem_model[wa + 2], mem_model[wa + 1], mem_model[wa]};
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'd0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'd0, h};
            default: return w;
        endcase
    endfunction

    // little endian, misaligned addresses drop their low bits
    function automatic void store_model(input logic [ADDR_WIDTH-1:0] addr, input func3_t f3,
                                        input data_t d);
        logic [ADDR_WIDTH-1:0] hb;
        logic [ADDR_WIDTH-1:0] wa;
        int                    i;
        hb = {addr[ADDR_WIDTH-1:1], 1'b0};
        wa = {addr[ADDR_WIDTH-1:2], 2'b00};
        case (f3[1:0])
            2'd0: mem_model[addr] = d[7:0];
            2'd1:
            begin
                mem_model[hb]     = d[7:0];
                mem_model[hb + 1] = d[15:8];
            end
            default:
            begin
                for (i = 0; i < 4; i++)
                begin
                    mem_model[wa + i] = d[8*i +: 8];
                end
            end
        endcase
    endfunction

    function automatic void apply_model(input inst_kind_t kind, input alu_op_t op,
                                        input func3_t f3, input rd_t rd, input data_t s1,
                                        input data_t s2, input data_t imm, input int cyc);
        data_t sum;
        sum = s1 + imm;
        case (kind)
            INST_STORE: store_model(sum[ADDR_WIDTH-1:0], f3, s2);
            INST_LOAD:
            begin
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(load_model(sum[ADDR_WIDTH-1:0], f3));
                exp_cyc_q.push_back(cyc);
            end
            default:
            begin
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(alu_model(op, s1, s2));
                exp_cyc_q.push_back(cyc);
            end
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_rd(input string name, input rd_t exp, input rd_t act);
        if (act !== exp)
        begin
            abort_run($sformatf("FAIL time %0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
        begin
            abort_run($sformatf("FAIL time %0t %s expected %08h actual %08h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp)
        begin
            abort_run($sformatf("FAIL time %0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    // holds the instruction until in_allow_o, then records it in the model
    task automatic issue(input inst_kind_t kind, input alu_op_t op, input func3_t f3,
                         input rd_t rd, input data_t s1, input data_t s2, input data_t imm,
                         input bit flushed, input bit timed);
        int accept_cyc;
        @(posedge clk);
        #2;
        in_valid_i  = 1'b1;
        in_kind_i   = kind;
        in_alu_op_i = op;
        in_func3_i  = f3;
        in_rd_i     = rd;
        in_src1_i   = s1;
        in_src2_i   = s2;
        in_imm_i    = imm;
        @(negedge clk);
        while (!in_allow_o)
        begin
            @(negedge clk);
        end
        accept_cyc = cycle_cnt;
        if (flushed)
        begin
            // one cycle in execute, then dropped on its way to memory
            @(posedge clk);
            #2;
            in_valid_i = 1'b0;
            flush_i    = 1'b1;
            @(posedge clk);
            #2;
            flush_i = 1'b0;
        end
        else
        begin
            apply_model(kind, op, f3, rd, s1, s2, imm, timed ? accept_cyc : -1);
        end
    endtask

    // random upper bits land above the RAM range
    task automatic pick_address(input int base, input int span, output data_t s1,
                                output data_t imm);
        data_t target;
        data_t upper;
        target = data_t'(base + rand_below(span));
        s1     = rand_word();
        upper  = data_t'(rand_below(65536)) << 16;
        imm    = target - s1 + upper;
    endtask

    task automatic send_alu(input bit timed, input bit flushed);
        alu_op_t op;
        rd_t     rd;
        data_t   s1;
        data_t   s2;
        data_t   imm;
        op  = alu_op_t'(rand_below(8));
        rd  = rd_t'(rand_below(32));
        s1  = rand_word();
        s2  = rand_word();
        imm = rand_word();
        issue(INST_ALU, op, F3_W, rd, s1, s2, imm, flushed, timed);
    endtask

    task automatic send_load(input int base, input int span, input bit word_only,
                             input bit flushed);
        func3_t f3;
        rd_t    rd;
        data_t  s1;
        data_t  imm;
        case (word_only ? 2 : rand_below(5))
            0:       f3 = F3_B;
            1:       f3 = F3_H;
            3:       f3 = F3_BU;
            4:       f3 = F3_HU;
            default: f3 = F3_W;
        endcase
        rd = rd_t'(rand_below(32));
        pick_address(base, span, s1, imm);
        issue(INST_LOAD, ALU_ADD, f3, rd, s1, 32'd0, imm, flushed, 1'b0);
    endtask

    // size_sel 0 word, 1 byte or half, 2 any size
    task automatic send_store(input int size_sel, input int base, input int span,
                              input bit flushed);
        func3_t f3;
        data_t  d;
        data_t  s1;
        data_t  imm;
        case (size_sel)
            0:       f3 = F3_W;
            1:       f3 = (rand_below(2) == 0) ? F3_B : F3_H;
            default: f3 = func3_t'(rand_below(3));
        endcase
        d = rand_word();
        pick_address(base, span, s1, imm);
        issue(INST_STORE, ALU_ADD, f3, 5'd0, s1, d, imm, flushed, 1'b0);
    endtask

    task automatic drain();
        @(posedge clk);
        #2;
        in_valid_i = 1'b0;
        while (exp_rd_q.size() != 0)
        begin
            @(negedge clk);
        end
        // stores retire silently, give a pending merge time to land
        repeat (5) @(posedge clk);
    endtask

    // back-pressure, only while stall_en is set
    always @(posedge clk)
    begin
        #2;
        if (stall_en)
        begin
            stall_state = lcg_next(stall_state);
            hold_i      = (stall_state[31:29] == 3'd0);
            wb_ready_i  = (stall_state[27:26] != 2'd0);
        end
        else
        begin
            hold_i     = 1'b0;
            wb_ready_i = 1'b1;
        end
    end

    // sampled at negedge, a transfer completes on the following rising edge
    always @(negedge clk)
    begin
        if (rst_n && wb_valid_o && wb_ready_i)
        begin
            if (exp_rd_q.size() == 0)
            begin
                abort_run($sformatf("writeback of x%0d at time %0t with nothing outstanding",
                                    wb_rd_o, $time));
            end
            else
            begin
                check_rd("wb_rd_o", exp_rd_q.pop_front(), wb_rd_o);
                check_data("wb_data_o", exp_data_q.pop_front(), wb_data_o);
                wb_cyc = exp_cyc_q.pop_front();
                if (wb_cyc >= 0)
                begin
                    check_latency("writeback latency", 3, cycle_cnt - wb_cyc);
                end
            end
        end
    end

    initial
    begin
        #(CLK_PERIOD * (RESET_CYCLES + 40 * TOTAL_INSTS));
        abort_run($sformatf("watchdog expired, the pipeline stopped retiring with %0d left",
                            exp_rd_q.size()));
    end

    initial
    begin
        int i;
        int base;
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush_i     = 1'b0;
        hold_i      = 1'b0;
        wb_ready_i  = 1'b1;
        in_valid_i  = 1'b0;
        in_kind_i   = INST_ALU;
        in_alu_op_i = ALU_ADD;
        in_func3_i  = F3_W;
        in_rd_i     = '0;
        in_src1_i   = '0;
        in_src2_i   = '0;
        in_imm_i    = '0;
        stim_state  = SEED;
        stall_state = ~SEED;
        stall_en    = 1'b0;
        for (i = 0; i < RAM_BYTES; i++)
        begin
            mem_model[i] = 8'h00;
        end

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (!in_allow_o || wb_valid_o)
        begin
            abort_run("in_allow_o or wb_valid_o not at its reset value");
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;

        // back-to-back ALU ops, fixed latency
        for (i = 0; i < N_ALU; i++)
        begin
            send_alu(1'b1, 1'b0);
        end
        drain();

        // word stores, then loads from written and untouched words
        for (i = 0; i < N_WSTORE; i++)
        begin
            send_store(0, 0, 64, 1'b0);
        end
        for (i = 0; i < N_WLOAD; i++)
        begin
            send_load((i % 2 == 0) ? 0 : 'h400, 64, 1'b1, 1'b0);
        end
        drain();

        // sub-word stores mixed with all load sizes
        for (i = 0; i < N_SUB; i++)
        begin
            if (i < 20 || rand_below(2) == 0)
            begin
                send_store(1, 0, 64, 1'b0);
            end
            else
            begin
                send_load(0, 64, 1'b0, 1'b0);
            end
        end
        drain();

        stall_en = 1'b1;
        for (i = 0; i < N_MIX; i++)
        begin
            case (rand_below(3))
                0:       send_alu(1'b0, 1'b0);
                1:       send_load(0, 64, 1'b0, 1'b0);
                default: send_store(2, 0, 64, 1'b0);
            endcase
        end
        stall_en = 1'b0;
        drain();

        // flushed op followed by one that must survive
        for (i = 0; i < N_FLUSH; i++)
        begin
            case (i % 3)
                0:
                begin
                    send_alu(1'b0, 1'b1);
                    send_alu(1'b0, 1'b0);
                end
                1:
                begin
                    send_load(0, 64, 1'b0, 1'b1);
                    send_alu(1'b0, 1'b0);
                end
                default:
                begin
                    base = rand_below(16) * 4;
                    send_store(2, base, 4, 1'b1);
                    send_load(base, 4, 1'b1, 1'b0);
                end
            endcase
            drain();
        end

        if (exp_rd_q.size() != 0)
        begin
            abort_run($sformatf("%0d expected writebacks never arrived", exp_rd_q.size()));
        end
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_pipe.f ====
verilog/lsu_pipe_pkg.sv
verilog/ex_stage.sv
verilog/ex_mem.sv
verilog/data_ram.sv
verilog/mem_wb.sv
verilog/lsu_pipe_top.sv
testbench/tb_lsu_pipe.sv
